/* common/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Only one transaction is ever in flight, so a single ID is enough.
  localparam logic [3:0] AXI_ID = 4'd0;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  localparam logic [2:0] AXI_SIZE_4B = 3'b010; // Four bytes per beat.

  localparam logic [1:0] AXI_LOCK_NORMAL = 2'b00;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // Normal non-cacheable bufferable memory.
  localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011;

  // Data access, secure, unprivileged.
  localparam logic [2:0] AXI_PROT_DEFAULT = 3'b000;

endpackage

`default_nettype wire

/* common/biu_pkg.sv */
`default_nettype none

package biu_pkg;

  // Opcodes on the core request port.
  typedef enum logic [1:0] {
    BIU_READ_WORD  = 2'd0,
    BIU_READ_LINE  = 2'd1, // INCR burst of a whole cache line.
    BIU_WRITE_WORD = 2'd2
  } biu_op_e;

  // States of the bus interface unit FSM.
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_READ_ADDR  = 3'd1,
    ST_READ_DATA  = 3'd2,
    ST_WRITE      = 3'd3, // AW and W are issued together.
    ST_WRITE_RESP = 3'd4
  } biu_state_e;

endpackage

`default_nettype wire

/* biu/biu_fsm.sv */
`default_nettype none

module biu_fsm (
  input  wire              aclk,
  input  wire              reset,
  input  wire              req_valid,
  input  wire biu_pkg::biu_op_e req_op,
  output logic             req_ready,
  output logic             capture,
  output logic             arvalid,
  input  wire              arready,
  input  wire              rvalid,
  input  wire        [1:0] rresp,
  output logic             rready,
  output logic             awvalid,
  input  wire              awready,
  output logic             wvalid,
  input  wire              wready,
  input  wire              bvalid,
  input  wire        [1:0] bresp,
  output logic             bready,
  input  wire              burst_end,
  input  wire              beat_err,
  output logic             resp_valid,
  output logic             resp_err
);
  import axi_pkg::*;
  import biu_pkg::*;

  biu_state_e state;
  biu_state_e state_next;
  logic       aw_done;
  logic       w_done;
  logic       r_hs;
  logic       aw_hs;
  logic       w_hs;
  logic       b_hs;
  logic       write_phase_done;
  logic       err_q;

  assign capture = req_valid && req_ready;

  // Channel valid and ready signals decode straight from the state register.
  assign arvalid = (state == ST_READ_ADDR);
  assign rready  = (state == ST_READ_DATA);
  assign awvalid = (state == ST_WRITE) && !aw_done;
  assign wvalid  = (state == ST_WRITE) && !w_done;
  assign bready  = (state == ST_WRITE_RESP);

  assign r_hs  = rvalid && rready;
  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;

  // AW and W may complete in either order or in the same cycle.
  assign write_phase_done = (aw_done || aw_hs) && (w_done || w_hs);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (capture) begin
          state_next = (req_op == BIU_WRITE_WORD) ? ST_WRITE : ST_READ_ADDR;
        end
      end
      ST_READ_ADDR: begin
        if (arready) state_next = ST_READ_DATA;
      end
      ST_READ_DATA: begin
        if (burst_end) state_next = ST_IDLE; // Ends on the beat carrying rlast.
      end
      ST_WRITE: begin
        if (write_phase_done) state_next = ST_WRITE_RESP;
      end
      ST_WRITE_RESP: begin
        if (bvalid) state_next = ST_IDLE;
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      state      <= ST_IDLE;
      req_ready  <= 1'b0; // Held low until the first edge out of reset.
      resp_valid <= 1'b0;
    end else begin
      state      <= state_next;
      req_ready  <= (state_next == ST_IDLE);
      resp_valid <= (rready && burst_end) || b_hs;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset || capture) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      aw_done <= aw_done || aw_hs;
      w_done  <= w_done || w_hs;
    end
  end

  // Sticky over one transaction, any non-OKAY response counts.
  always_ff @(posedge aclk) begin
    if (reset || capture) begin
      err_q <= 1'b0;
    end else if ((r_hs && rresp != AXI_RESP_OKAY) || (b_hs && bresp != AXI_RESP_OKAY) ||
                 beat_err) begin
      err_q <= 1'b1;
    end
  end

  // beat_err lands in the same cycle as resp_valid, so it is merged here.
  assign resp_err = err_q || beat_err;

endmodule

`default_nettype wire

/* biu/beat_counter.sv */
`default_nettype none

module beat_counter #(
  parameter int LINE_WORDS = 4
) (
  input  wire                            aclk,
  input  wire                            reset,
  input  wire                            capture,
  input  wire biu_pkg::biu_op_e          req_op,
  input  wire                            rvalid,
  input  wire                            rready,
  input  wire                            rlast,
  output logic                           beat_we,
  output logic [$clog2(LINE_WORDS)-1:0]  beat_index,
  output logic                           burst_end,
  output logic                           beat_err
);
  import biu_pkg::*;

  localparam int CNT_W = $clog2(LINE_WORDS) + 1; // One extra bit to hold LINE_WORDS.

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] expected;
  logic             r_hs;
  logic             last_expected;

  assign r_hs          = rvalid && rready;
  assign last_expected = (count == expected - 1'b1);

  assign beat_we    = r_hs && (count < expected); // Surplus beats are dropped.
  assign beat_index = count[CNT_W-2:0];
  assign burst_end  = r_hs && rlast;

  always_ff @(posedge aclk) begin
    if (reset) begin
      count    <= '0;
      expected <= CNT_W'(1);
      beat_err <= 1'b0;
    end else if (capture) begin
      count    <= '0;
      expected <= (req_op == BIU_READ_LINE) ? CNT_W'(LINE_WORDS) : CNT_W'(1);
      beat_err <= 1'b0;
    end else if (r_hs) begin
      if (count != expected) count <= count + 1'b1;
      if (rlast != last_expected) beat_err <= 1'b1; // rlast early, or missing on the final beat.
    end
  end

endmodule

`default_nettype wire

/* biu/req_register.sv */
`default_nettype none

module req_register #(
  parameter int LINE_WORDS = 4
) (
  input  wire                              aclk,
  input  wire                              reset,
  input  wire                              capture,
  input  wire biu_pkg::biu_op_e            req_op,
  input  wire  [axi_pkg::ADDR_W-1:0]       req_addr,
  input  wire  [axi_pkg::DATA_W-1:0]       req_wdata,
  input  wire  [axi_pkg::DATA_W/8-1:0]     req_wstrb,
  output logic [axi_pkg::ADDR_W-1:0]       araddr,
  output logic [7:0]                       arlen,
  output logic [axi_pkg::ADDR_W-1:0]       awaddr,
  output logic [7:0]                       awlen,
  output logic [axi_pkg::DATA_W-1:0]       wdata,
  output logic [axi_pkg::DATA_W/8-1:0]     wstrb
);
  import axi_pkg::*;
  import biu_pkg::*;

  localparam int LINE_OFF_W = $clog2(LINE_WORDS) + 2; // Byte offset bits within a line.

  logic [ADDR_W-1:0] addr_q;
  logic [7:0]        len_q;
  logic [ADDR_W-1:0] line_addr;
  logic [ADDR_W-1:0] word_addr;

  assign line_addr = {req_addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  assign word_addr = {req_addr[ADDR_W-1:2], 2'b00};

  always_ff @(posedge aclk) begin
    if (reset) begin
      addr_q <= '0;
      len_q  <= '0;
    end else if (capture) begin
      if (req_op == BIU_READ_LINE) begin
        addr_q <= line_addr;
        len_q  <= 8'(LINE_WORDS - 1);
      end else begin
        addr_q <= word_addr;
        len_q  <= 8'd0; // Single beat.
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (capture) begin
      wdata <= req_wdata;
      wstrb <= req_wstrb;
    end
  end

  // Reads and writes never overlap, so one address register serves both.
  assign araddr = addr_q;
  assign awaddr = addr_q;
  assign arlen  = len_q;
  assign awlen  = len_q;

endmodule

`default_nettype wire

/* biu/line_buffer.sv */
`default_nettype none

module line_buffer #(
  parameter int LINE_WORDS = 4
) (
  input  wire                                     aclk,
  input  wire                                     reset,
  input  wire                                     beat_we,
  input  wire  [$clog2(LINE_WORDS)-1:0]           beat_index,
  input  wire  [axi_pkg::DATA_W-1:0]              rdata,
  output logic [LINE_WORDS*axi_pkg::DATA_W-1:0]   resp_rdata
);
  import axi_pkg::*;

  logic [DATA_W-1:0] slots [LINE_WORDS];

  always_ff @(posedge aclk) begin
    if (reset) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        slots[i] <= '0;
      end
    end else if (beat_we) begin
      slots[beat_index] <= rdata; // Beat order follows the INCR address order.
    end
  end

  // Word 0 sits in the low bits of the response.
  always_comb begin
    for (int i = 0; i < LINE_WORDS; i++) begin
      resp_rdata[i*DATA_W +: DATA_W] = slots[i];
    end
  end

endmodule

`default_nettype wire

/* verilog/biu_top.sv */
`default_nettype none

module biu_top #(
  parameter int LINE_WORDS = 4
) (
  input  wire                                    aclk,
  input  wire                                    reset,
  // Core request and response.
  input  wire                                    req_valid,
  input  wire biu_pkg::biu_op_e                  req_op,
  input  wire  [axi_pkg::ADDR_W-1:0]             req_addr,
  input  wire  [axi_pkg::DATA_W-1:0]             req_wdata,
  input  wire  [axi_pkg::DATA_W/8-1:0]           req_wstrb,
  output logic                                   req_ready,
  output logic                                   resp_valid,
  output logic                                   resp_err,
  output logic [LINE_WORDS*axi_pkg::DATA_W-1:0]  resp_rdata,
  // Read address.
  output logic [3:0]                             arid,
  output logic [axi_pkg::ADDR_W-1:0]             araddr,
  output logic [7:0]                             arlen,
  output logic [2:0]                             arsize,
  output logic [1:0]                             arburst,
  output logic [1:0]                             arlock,
  output logic [3:0]                             arcache,
  output logic [2:0]                             arprot,
  output logic                                   arvalid,
  input  wire                                    arready,
  // Read data.
  input  wire  [3:0]                             rid,
  input  wire  [axi_pkg::DATA_W-1:0]             rdata,
  input  wire  [1:0]                             rresp,
  input  wire                                    rlast,
  input  wire                                    rvalid,
  output logic                                   rready,
  // Write address.
  output logic [3:0]                             awid,
  output logic [axi_pkg::ADDR_W-1:0]             awaddr,
  output logic [7:0]                             awlen,
  output logic [2:0]                             awsize,
  output logic [1:0]                             awburst,
  output logic [1:0]                             awlock,
  output logic [3:0]                             awcache,
  output logic [2:0]                             awprot,
  output logic                                   awvalid,
  input  wire                                    awready,
  // Write data.
  output logic [3:0]                             wid,
  output logic [axi_pkg::DATA_W-1:0]             wdata,
  output logic [axi_pkg::DATA_W/8-1:0]           wstrb,
  output logic                                   wlast,
  output logic                                   wvalid,
  input  wire                                    wready,
  // Write response.
  input  wire  [3:0]                             bid,
  input  wire  [1:0]                             bresp,
  input  wire                                    bvalid,
  output logic                                   bready
);
  import axi_pkg::*;

  logic                          reset_q;
  logic                          capture;
  logic                          burst_end;
  logic                          beat_err;
  logic                          beat_we;
  logic [$clog2(LINE_WORDS)-1:0] beat_index;

  always_ff @(posedge aclk) begin
    reset_q <= reset; // All blocks see reset one cycle late.
  end

  // rid and bid carry no information with a single outstanding transaction.
  assign arid    = AXI_ID;
  assign arsize  = AXI_SIZE_4B;
  assign arburst = AXI_BURST_INCR;
  assign arlock  = AXI_LOCK_NORMAL;
  assign arcache = AXI_CACHE_DEFAULT;
  assign arprot  = AXI_PROT_DEFAULT;
  assign awid    = AXI_ID;
  assign awsize  = AXI_SIZE_4B;
  assign awburst = AXI_BURST_INCR;
  assign awlock  = AXI_LOCK_NORMAL;
  assign awcache = AXI_CACHE_DEFAULT;
  assign awprot  = AXI_PROT_DEFAULT;
  assign wid     = AXI_ID;
  assign wlast   = 1'b1; // Writes are always a single beat.

  biu_fsm biu_fsm_inst (
    .aclk      (aclk),
    .reset     (reset_q),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_ready (req_ready),
    .capture   (capture),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rresp     (rresp),
    .rready    (rready),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .burst_end (burst_end),
    .beat_err  (beat_err),
    .resp_valid(resp_valid),
    .resp_err  (resp_err)
  );

  beat_counter #(.LINE_WORDS(LINE_WORDS)) beat_counter_inst (
    .aclk      (aclk),
    .reset     (reset_q),
    .capture   (capture),
    .req_op    (req_op),
    .rvalid    (rvalid),
    .rready    (rready),
    .rlast     (rlast),
    .beat_we   (beat_we),
    .beat_index(beat_index),
    .burst_end (burst_end),
    .beat_err  (beat_err)
  );

  req_register #(.LINE_WORDS(LINE_WORDS)) req_register_inst (
    .aclk     (aclk),
    .reset    (reset_q),
    .capture  (capture),
    .req_op   (req_op),
    .req_addr (req_addr),
    .req_wdata(req_wdata),
    .req_wstrb(req_wstrb),
    .araddr   (araddr),
    .arlen    (arlen),
    .awaddr   (awaddr),
    .awlen    (awlen),
    .wdata    (wdata),
    .wstrb    (wstrb)
  );

  line_buffer #(.LINE_WORDS(LINE_WORDS)) line_buffer_inst (
    .aclk      (aclk),
    .reset     (reset_q),
    .beat_we   (beat_we),
    .beat_index(beat_index),
    .rdata     (rdata),
    .resp_rdata(resp_rdata)
  );

endmodule

`default_nettype wire

/* verification/axi_slave_model.sv */
`default_nettype none

module axi_slave_model #(
  parameter int LINE_WORDS = 4
) (
  input  wire                          aclk,
  input  wire                          reset,
  input  wire                          stall_en,
  input  wire                          slverr_en,
  input  wire                          early_last_en,
  input  wire  [axi_pkg::ADDR_W-1:0]   araddr,
  input  wire  [7:0]                   arlen,
  input  wire                          arvalid,
  output logic                         arready,
  output logic [axi_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                   rresp,
  output logic                         rlast,
  output logic                         rvalid,
  input  wire                          rready,
  input  wire  [axi_pkg::ADDR_W-1:0]   awaddr,
  input  wire                          awvalid,
  output logic                         awready,
  input  wire  [axi_pkg::DATA_W-1:0]   wdata,
  input  wire  [axi_pkg::DATA_W/8-1:0] wstrb,
  input  wire                          wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  wire                          bready
);
  timeunit 1ns;
  timeprecision 100ps;

  import axi_pkg::*;

  logic [DATA_W-1:0]   mem [256]; // 1 KiB of word storage.
  logic [31:0]         lfsr;
  logic [31:0]         lfsr_next;
  logic [4:0]          go; // Gates for AR, R, AW, W and B in that order.
  logic                r_active;
  logic [7:0]          r_beat;
  logic [7:0]          r_last_beat;
  logic [ADDR_W-1:0]   r_addr;
  logic                aw_got;
  logic                w_got;
  logic                b_pend;
  logic [ADDR_W-1:0]   aw_addr;
  logic [DATA_W-1:0]   w_data;
  logic [DATA_W/8-1:0] w_strb;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  always_comb begin
    lfsr_next = lfsr;
    for (int i = 0; i < 5; i++) begin
      go[i] = !stall_en || lfsr_next[0]; // One LFSR step per gate bit.
      lfsr_next = lfsr_step(lfsr_next);
    end
  end

  assign arready = !r_active && go[0];
  assign awready = !aw_got && go[2];
  assign wready  = !w_got && go[3];
  assign rdata   = mem[r_addr[9:2]];
  assign rresp   = AXI_RESP_OKAY;
  assign rlast   = (r_beat == r_last_beat);
  assign bresp   = slverr_en ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

  always_ff @(posedge aclk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= (i * 4) ^ 32'h5a5a_0000;
      end
      lfsr     <= 32'hfb78;
      r_active <= 1'b0;
      rvalid   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      b_pend   <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      lfsr <= lfsr_next;
      if (arvalid && arready) begin
        r_active    <= 1'b1;
        r_addr      <= araddr;
        r_beat      <= '0;
        // Only a full line burst is cut short.
        r_last_beat <= (early_last_en && arlen == 8'(LINE_WORDS - 1)) ? arlen - 8'd1 : arlen;
      end
      if (rvalid && rready) begin
        r_addr   <= r_addr + 32'd4;
        r_beat   <= r_beat + 8'd1;
        r_active <= !rlast;
        rvalid   <= !rlast && go[1];
      end else if (r_active && go[1]) begin
        rvalid <= 1'b1;
      end
      if (awvalid && awready) begin
        aw_got  <= 1'b1;
        aw_addr <= awaddr;
      end
      if (wvalid && wready) begin
        w_got  <= 1'b1;
        w_data <= wdata;
        w_strb <= wstrb;
      end
      if (aw_got && w_got && !b_pend) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (w_strb[b]) mem[aw_addr[9:2]][b*8 +: 8] <= w_data[b*8 +: 8];
        end
        b_pend <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_pend <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end else if (b_pend && go[4]) begin
        bvalid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_biu.sv */
`default_nettype none

module tb_biu;
  timeunit 1ns;
  timeprecision 100ps;

  import axi_pkg::*;
  import biu_pkg::*;

  localparam int LINE_WORDS = 4;
  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS  = 6;
  localparam int RESP_LIMIT = 500;

  logic                         aclk = 1'b0;
  logic                         reset;
  logic                         req_valid;
  biu_op_e                      req_op;
  logic [ADDR_W-1:0]            req_addr;
  logic [DATA_W-1:0]            req_wdata;
  logic [DATA_W/8-1:0]          req_wstrb;
  logic                         req_ready, resp_valid, resp_err;
  logic [LINE_WORDS*DATA_W-1:0] resp_rdata;
  logic [ADDR_W-1:0]            araddr, awaddr;
  logic [7:0]                   arlen, awlen;
  logic [3:0]                   arid, awid, wid;
  logic [2:0]                   arsize, awsize;
  logic [1:0]                   arburst, awburst;
  logic [1:0]                   arlock, awlock;
  logic [3:0]                   arcache, awcache;
  logic [2:0]                   arprot, awprot;
  logic                         wlast;
  logic                         arvalid, arready, rvalid, rready, rlast;
  logic [DATA_W-1:0]            rdata, wdata;
  logic [1:0]                   rresp, bresp;
  logic                         awvalid, awready, wvalid, wready, bvalid, bready;
  logic [DATA_W/8-1:0]          wstrb;
  logic                         stall_en, slverr_en, early_last_en;
  int                           errors = 0;
  int                           errors_before = 0;
  int                           passed = 0;
  int                           failed = 0;

  biu_top #(.LINE_WORDS(LINE_WORDS)) biu_top_inst (
    .aclk(aclk), .reset(reset),
    .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_wstrb(req_wstrb), .req_ready(req_ready),
    .resp_valid(resp_valid), .resp_err(resp_err), .resp_rdata(resp_rdata),
    .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
    .arlock(arlock), .arcache(arcache), .arprot(arprot),
    .arvalid(arvalid), .arready(arready),
    .rid(4'd0), .rdata(rdata), .rresp(rresp), .rlast(rlast),
    .rvalid(rvalid), .rready(rready),
    .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
    .awlock(awlock), .awcache(awcache), .awprot(awprot),
    .awvalid(awvalid), .awready(awready),
    .wid(wid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
    .wvalid(wvalid), .wready(wready),
    .bid(4'd0), .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

  axi_slave_model #(.LINE_WORDS(LINE_WORDS)) slave_inst (
    .aclk(aclk), .reset(reset), .stall_en(stall_en), .slverr_en(slverr_en),
    .early_last_en(early_last_en),
    .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

  initial begin
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles.", NUM_TESTS * 2000);
    $display("TB FAILED");
    $finish;
  end

  // Memory contents after reset.
  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return merged;
  endfunction

  task automatic check_value(input string name, input logic [LINE_WORDS*DATA_W-1:0] actual,
                             input logic [LINE_WORDS*DATA_W-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got %0h, expected %0h", name, actual, expected);
      errors++;
    end
  endtask

  // Every transaction uses ID 0 and normal, secure, unprivileged 4-byte INCR beats.
  task automatic check_attributes();
    check_value("arid", arid, 4'h0);
    check_value("arsize", arsize, 3'b010);
    check_value("arburst", arburst, 2'b01);
    check_value("arlock", arlock, 2'b00);
    check_value("arcache", arcache, 4'b0011);
    check_value("arprot", arprot, 3'b000);
    check_value("awid", awid, 4'h0);
    check_value("awsize", awsize, 3'b010);
    check_value("awburst", awburst, 2'b01);
    check_value("awlock", awlock, 2'b00);
    check_value("awcache", awcache, 4'b0011);
    check_value("awprot", awprot, 3'b000);
    check_value("wid", wid, 4'h0);
    check_value("wlast", wlast, 1'b1);
  endtask

  task automatic report_test(input string name);
    if (errors == errors_before) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d mismatches", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // Returns on the falling edge where resp_valid is high.
  task automatic run_request(input biu_op_e op, input logic [31:0] addr,
                             input logic [31:0] wd, input logic [3:0] ws);
    int waited;
    @(negedge aclk);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wd;
    req_wstrb = ws;
    while (!req_ready) @(negedge aclk);
    @(negedge aclk);
    req_valid = 1'b0;
    waited = 0;
    while (!resp_valid && waited < RESP_LIMIT) begin
      @(negedge aclk);
      waited++;
    end
    if (!resp_valid) begin
      $display("No response within %0d cycles for the request at address %h.",
               RESP_LIMIT, addr);
      errors++;
    end
  endtask

  task automatic reset_sequence();
    int cycles;
    reset = 1'b1;
    repeat (4) @(negedge aclk);
    reset  = 1'b0;
    cycles = 0;
    do begin
      @(negedge aclk);
      cycles++;
      check_value("arvalid", arvalid, 1'b0);
      check_value("awvalid", awvalid, 1'b0);
      check_value("wvalid", wvalid, 1'b0);
      check_value("resp_valid", resp_valid, 1'b0);
    end while (!req_ready && cycles < 16);
    check_value("req_ready", req_ready, 1'b1);
    check_value("req_ready_delay", cycles, 2); // Two edges through the reset register.
    report_test("reset");
  endtask

  task automatic word_read();
    run_request(BIU_READ_WORD, 32'h0000_0106, '0, '0);
    check_value("resp_rdata[0]", resp_rdata[DATA_W-1:0], init_word(32'h0000_0106));
    check_value("resp_err", resp_err, 1'b0);
    check_attributes();
    report_test("word read");
  endtask

  task automatic line_read(input logic stall, input logic [31:0] addr);
    logic [31:0] base;
    base     = addr & ~32'(LINE_WORDS * 4 - 1);
    stall_en = stall;
    run_request(BIU_READ_LINE, addr, '0, '0);
    for (int i = 0; i < LINE_WORDS; i++) begin
      check_value($sformatf("resp_rdata[%0d]", i), resp_rdata[i*DATA_W +: DATA_W],
                  init_word(base + 4 * i));
    end
    check_value("resp_err", resp_err, 1'b0);
    check_value("arlen", arlen, LINE_WORDS - 1);
    stall_en = 1'b0;
    report_test(stall ? "line read with stalls" : "line read");
  endtask

  task automatic write_then_read();
    logic [31:0] expected;
    expected = merge_bytes(init_word(32'h0000_0080), 32'ha1b2_c3d4, 4'b0101);
    stall_en = 1'b1;
    run_request(BIU_WRITE_WORD, 32'h0000_0080, 32'ha1b2_c3d4, 4'b0101);
    check_value("resp_err", resp_err, 1'b0);
    check_value("awlen", awlen, 8'd0);
    check_attributes();
    run_request(BIU_READ_WORD, 32'h0000_0080, '0, '0);
    check_value("resp_rdata[0]", resp_rdata[DATA_W-1:0], expected);
    check_value("resp_err", resp_err, 1'b0);
    stall_en = 1'b0;
    report_test("write then read");
  endtask

  task automatic error_injection();
    slverr_en = 1'b1;
    run_request(BIU_WRITE_WORD, 32'h0000_0300, 32'h1234_5678, 4'b1111);
    check_value("resp_err", resp_err, 1'b1);
    slverr_en     = 1'b0;
    early_last_en = 1'b1;
    run_request(BIU_READ_LINE, 32'h0000_0340, '0, '0);
    check_value("resp_err", resp_err, 1'b1);
    early_last_en = 1'b0;
    run_request(BIU_READ_WORD, 32'h0000_0344, '0, '0);
    check_value("resp_rdata[0]", resp_rdata[DATA_W-1:0], init_word(32'h0000_0344));
    check_value("resp_err", resp_err, 1'b0);
    report_test("error injection");
  endtask

  initial begin
    reset         = 1'b1;
    req_valid     = 1'b0;
    req_op        = BIU_READ_WORD;
    req_addr      = '0;
    req_wdata     = '0;
    req_wstrb     = '0;
    stall_en      = 1'b0;
    slverr_en     = 1'b0;
    early_last_en = 1'b0;
    reset_sequence();
    word_read();
    line_read(1'b0, 32'h0000_0234);
    line_read(1'b1, 32'h0000_01c8);
    write_then_read();
    error_injection();
    $display("tests passed: %0d, tests failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
common/axi_pkg.sv
common/biu_pkg.sv
biu/biu_fsm.sv
biu/beat_counter.sv
biu/req_register.sv
biu/line_buffer.sv
verilog/biu_top.sv
verification/axi_slave_model.sv
verification/tb_biu.sv

/* Bender.yml */
package:
  name: biu

sources:
  - common/axi_pkg.sv
  - common/biu_pkg.sv
  - biu/biu_fsm.sv
  - biu/beat_counter.sv
  - biu/req_register.sv
  - biu/line_buffer.sv
  - verilog/biu_top.sv
  - target: simulation
    files:
      - verification/axi_slave_model.sv
      - verification/tb_biu.sv
